// ==== src/cpc_loader_pkg.sv ====
package cpc_loader_pkg;

	//////////////////////////////////////////////////
	// Widths

	localparam int DL_ADDR_W  = 25;
	localparam int MEM_ADDR_W = 23;
	localparam int PAGE_W     = 9;   // Top bit selects the ROM area
	localparam int OFFSET_W   = 14;  // 16 KB page
	localparam int SLOT_W     = DL_ADDR_W - OFFSET_W;
	localparam int STEP_W     = PAGE_W - 1;

	// Download indices
	localparam logic [7:0] DL_IDX_ROM = 8'd0;
	localparam logic [7:0] DL_IDX_EXT = 8'd3;

	// Slots of a system ROM image that land somewhere
	localparam int ROM_SLOTS = 8;

	//////////////////////////////////////////////////
	// ROM pages

	localparam logic [PAGE_W-1:0] PAGE_LOWER_ROM = 9'h000;
	localparam logic [PAGE_W-1:0] PAGE_BASIC_ROM = 9'h100;
	localparam logic [PAGE_W-1:0] PAGE_DISK_ROM  = 9'h107;
	localparam logic [PAGE_W-1:0] PAGE_TOP       = 9'h1FF;

	// Spare page, used when the extension makes no sense
	localparam logic [PAGE_W-1:0] PAGE_MALFORMED = 9'h1EE;

	//////////////////////////////////////////////////
	// Download address, seen as ROM slot or as expansion step

	typedef union packed {
		struct packed {
			logic [SLOT_W-1:0]   slot;
			logic [OFFSET_W-1:0] offset;
		} rom_view;
		struct packed {
			logic [DL_ADDR_W-OFFSET_W-STEP_W-1:0] unused;
			logic [STEP_W-1:0]                    step;   // Added to start page
			logic [OFFSET_W-1:0]                  offset;
		} ext_view;
	} dl_addr_u;

endpackage

// ==== src/mem_write_if.sv ====
interface mem_write_if import cpc_loader_pkg::*; ();

	logic                  valid;
	logic                  ready;
	logic [MEM_ADDR_W-1:0] addr;
	logic                  bank;
	logic [7:0]            data;

	// Loader side
	modport source (
		output valid,
		output addr,
		output bank,
		output data,
		input  ready
	);

	// Memory side
	modport sink (
		input  valid,
		input  addr,
		input  bank,
		input  data,
		output ready
	);

	// Watches accepted writes only
	modport monitor (
		input valid,
		input ready,
		input addr
	);

endinterface

// ==== src/ext_page_decoder.sv ====
module ext_page_decoder import cpc_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              dl_active,
	input  logic [7:0]        dl_index,
	input  logic [15:0]       dl_ext,     // Last two extension characters
	input  logic              dl_valid,
	input  logic              dl_ready,
	input  dl_addr_u          dl_addr,
	output logic [PAGE_W-1:0] page,
	output logic              page_ok
);

	// {is hex, value} of one ASCII character
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			return {1'b1, 4'(c[3:0] + 4'd9)};
		else
			return 5'd0;
	endfunction

	logic              dl_active_q;
	logic              combo;
	logic              ext_sel;
	logic              ext_start;
	logic              ext_take;
	logic              is_combo_ext;
	logic [4:0]        hi_digit;
	logic [4:0]        lo_digit;
	logic [PAGE_W-1:0] start_page;

	assign ext_sel   = dl_index == DL_IDX_EXT;
	assign ext_start = dl_active & ~dl_active_q & ext_sel;
	assign ext_take  = dl_valid & dl_ready & ext_sel;

	assign hi_digit     = hex_digit(dl_ext[15:8]);
	assign lo_digit     = hex_digit(dl_ext[7:0]);
	assign is_combo_ext = dl_ext == "Z0";

	//////////////////////////////////////////////////
	// Start page from the extension

	always_comb begin
		start_page = PAGE_MALFORMED;
		if (hi_digit[4])
			start_page[7:4] = hi_digit[3:0];
		if (lo_digit[4])
			start_page[3:0] = lo_digit[3:0];
		if (dl_ext == "ZZ" || is_combo_ext)
			start_page = PAGE_LOWER_ROM;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			page        <= PAGE_MALFORMED;
			combo       <= 1'b0;
			page_ok     <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			page_ok     <= dl_active & ext_sel & (ext_start | page_ok);

			// Combo image moves on after its first 16 KB
			if (combo && ext_take && &dl_addr.ext_view.offset) begin
				page  <= PAGE_TOP;
				combo <= 1'b0;
			end

			if (ext_start) begin  // New download wins
				page  <= start_page;
				combo <= is_combo_ext;
			end
		end
	end

endmodule

// ==== src/boot_addr_map.sv ====
module boot_addr_map import cpc_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic [7:0]        dl_index,
	input  logic              dl_valid,
	output logic              dl_ready,
	input  dl_addr_u          dl_addr,
	input  logic [7:0]        dl_data,
	input  logic              model,     // Bank for expansion writes
	input  logic [PAGE_W-1:0] page,
	input  logic              page_ok,
	mem_write_if.source       mem
);

	logic                  take;
	logic                  ext_wait;
	logic                  map_keep;
	logic [MEM_ADDR_W-1:0] map_addr;
	logic                  map_bank;
	logic [PAGE_W-1:0]     rom_page;

	logic                  out_valid;
	logic [MEM_ADDR_W-1:0] out_addr;
	logic                  out_bank;
	logic [7:0]            out_data;

	//////////////////////////////////////////////////
	// Address mapping

	// Same four pages for both banks
	always_comb begin
		case (dl_addr.rom_view.slot[1:0])
			2'd0:    rom_page = PAGE_LOWER_ROM;
			2'd1:    rom_page = PAGE_BASIC_ROM;
			2'd2:    rom_page = PAGE_DISK_ROM;
			default: rom_page = PAGE_TOP;
		endcase
	end

	always_comb begin
		map_keep = 1'b0;
		map_addr = {rom_page, dl_addr.rom_view.offset};
		map_bank = 1'b0;
		case (dl_index)
			DL_IDX_ROM: begin
				map_keep = dl_addr.rom_view.slot < ROM_SLOTS;
				map_bank = dl_addr.rom_view.slot[2];  // Slots 4..7
			end
			DL_IDX_EXT: begin
				map_keep = 1'b1;
				map_addr = {page[PAGE_W-1],
					STEP_W'(page[STEP_W-1:0] + dl_addr.ext_view.step),
					dl_addr.ext_view.offset};
				map_bank = model;
			end
			default: map_keep = 1'b0;  // Accept and forget
		endcase
	end

	//////////////////////////////////////////////////
	// One-entry output register

	// Hold expansion bytes until the start page is in
	assign ext_wait = (dl_index == DL_IDX_EXT) & ~page_ok;
	assign dl_ready = (~out_valid | mem.ready) & ~ext_wait;
	assign take     = dl_valid & dl_ready;

	always_ff @(posedge clk_sys) begin
		if (reset)
			out_valid <= 1'b0;
		else if (take && map_keep)
			out_valid <= 1'b1;
		else if (mem.ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (take && map_keep) begin
			out_addr <= map_addr;
			out_bank <= map_bank;
			out_data <= dl_data;
		end
	end

	assign mem.valid = out_valid;
	assign mem.addr  = out_addr;
	assign mem.bank  = out_bank;
	assign mem.data  = out_data;

endmodule

// ==== src/rom_page_table.sv ====
module rom_page_table import cpc_loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [MEM_ADDR_W-1:0] cpu_addr,
	output logic                  rom_mask,
	mem_write_if.monitor          mem
);

	// One flag per page in the ROM area
	logic [2**STEP_W-1:0] loaded;
	logic [STEP_W-1:0]    wr_page;
	logic [STEP_W-1:0]    rd_page;
	logic                 wr_rom;

	assign wr_page = mem.addr[MEM_ADDR_W-2:OFFSET_W];
	assign wr_rom  = mem.valid & mem.ready & mem.addr[MEM_ADDR_W-1];

	//////////////////////////////////////////////////
	// Table update on accepted writes

	always_ff @(posedge clk_sys) begin
		if (reset)
			loaded <= '0;
		else if (wr_rom)
			loaded[wr_page] <= 1'b1;
	end

	//////////////////////////////////////////////////
	// Query

	assign rd_page  = cpu_addr[MEM_ADDR_W-2:OFFSET_W];
	assign rom_mask = cpu_addr[MEM_ADDR_W-1] & ~loaded[rd_page];  // Empty ROM page

endmodule

// ==== src/cpc_loader_top.sv ====
module cpc_loader_top import cpc_loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,

	// Download stream
	input  logic                  dl_active,
	input  logic [7:0]            dl_index,
	input  logic [15:0]           dl_ext,
	input  logic                  dl_valid,
	output logic                  dl_ready,
	input  logic [DL_ADDR_W-1:0]  dl_addr,
	input  logic [7:0]            dl_data,

	input  logic                  model,

	// External memory writes
	output logic                  mem_valid,
	input  logic                  mem_ready,
	output logic [MEM_ADDR_W-1:0] mem_addr,
	output logic                  mem_bank,
	output logic [7:0]            mem_data,

	// ROM page query
	input  logic [MEM_ADDR_W-1:0] cpu_addr,
	output logic                  rom_mask
);

	logic [PAGE_W-1:0] page;
	logic              page_ok;

	mem_write_if u_mem ();

	//////////////////////////////////////////////////
	// Memory side ports

	assign u_mem.ready = mem_ready;
	assign mem_valid   = u_mem.valid;
	assign mem_addr    = u_mem.addr;
	assign mem_bank    = u_mem.bank;
	assign mem_data    = u_mem.data;

	ext_page_decoder u_ext_page_decoder (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_ext    (dl_ext),
		.dl_valid  (dl_valid),
		.dl_ready  (dl_ready),
		.dl_addr   (dl_addr),
		.page      (page),
		.page_ok   (page_ok)
	);

	boot_addr_map u_boot_addr_map (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_index (dl_index),
		.dl_valid (dl_valid),
		.dl_ready (dl_ready),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.model    (model),
		.page     (page),
		.page_ok  (page_ok),
		.mem      (u_mem.source)
	);

	rom_page_table u_rom_page_table (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.rom_mask (rom_mask),
		.mem      (u_mem.monitor)
	);

endmodule

// ==== tb/clock_gen.sv ====
module clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;  // Period 4
	end

	// Released just after the 8th rising edge
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	end

endmodule

// ==== tb/cpc_loader_props.sv ====
module cpc_loader_props import cpc_loader_pkg::*; (
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  valid,
	input logic                  ready,
	input logic [MEM_ADDR_W-1:0] addr,
	input logic                  bank,
	input logic [7:0]            data
);

	int fail_count = 0;  // Summed up at end of run

	valid_after_reset: assert property (@(posedge clk_sys) reset |=> !valid)
		else begin
			fail_count++;
			$error("memory valid high in the cycle after reset");
		end

	// Payload frozen while the write waits
	payload_stable: assert property (@(posedge clk_sys) disable iff (reset)
		valid && !ready |=> $stable({addr, bank, data}))
		else begin
			fail_count++;
			$error("memory payload changed while stalled");
		end

	valid_held: assert property (@(posedge clk_sys) disable iff (reset)
		valid && !ready |=> valid)
		else begin
			fail_count++;
			$error("memory valid dropped before ready");
		end

endmodule

bind boot_addr_map cpc_loader_props u_props (
	.clk_sys (clk_sys),
	.reset   (reset),
	.valid   (mem.valid),
	.ready   (mem.ready),
	.addr    (mem.addr),
	.bank    (mem.bank),
	.data    (mem.data)
);

// ==== tb/tb_cpc_loader.sv ====
module tb_cpc_loader import cpc_loader_pkg::*; ();

	logic                  clk_sys;
	logic                  reset;
	logic                  dl_active;
	logic [7:0]            dl_index;
	logic [15:0]           dl_ext;
	logic                  dl_valid;
	logic                  dl_ready;
	logic [DL_ADDR_W-1:0]  dl_addr;
	logic [7:0]            dl_data;
	logic                  model;
	logic                  mem_valid;
	logic                  mem_ready;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic                  mem_bank;
	logic [7:0]            mem_data;
	logic [MEM_ADDR_W-1:0] cpu_addr;
	logic                  rom_mask;

	logic [31:0]       rng = 32'd74508;
	logic              stall_en = 1'b0;
	logic [PAGE_W-1:0] ref_page = PAGE_MALFORMED;
	logic              ref_combo = 1'b0;
	logic              loaded_ref [256];
	logic [31:0]       expect_q [$];  // {bank, addr, data}
	logic [15:0]       ext_names [4] = '{"3C", "0F", "ZZ", "Q7"};
	string             test_name = "reset";

	clock_gen u_clock_gen (.clk_sys(clk_sys), .reset(reset));

	cpc_loader_top u_cpc_loader_top (.*);

	//////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// {combo, page} for an expansion file name
	function automatic logic [9:0] ext_start_page(input logic [15:0] ext);
		logic [8:0] p;
		logic [7:0] c;
		p = PAGE_MALFORMED;
		if (ext == "ZZ" || ext == "Z0")
			return {ext == "Z0", PAGE_LOWER_ROM};
		for (int i = 0; i < 2; i++) begin
			c = ext[15 - 8*i -: 8];
			if (c inside {["0":"9"]})
				p[7 - 4*i -: 4] = 4'(c - "0");
			else if (c inside {["A":"F"]})
				p[7 - 4*i -: 4] = 4'(c - "A" + 10);
		end
		return {1'b0, p};
	endfunction

	// {keep, bank, addr} for one download byte
	function automatic logic [24:0] expect_write(input logic [7:0] idx, input logic mdl,
			input logic [8:0] pg, input logic [24:0] a);
		logic [8:0] base [4];
		base = '{PAGE_LOWER_ROM, PAGE_BASIC_ROM, PAGE_DISK_ROM, PAGE_TOP};
		if (idx == DL_IDX_ROM && a[24:14] < 8)
			return {1'b1, a[24:14] >= 4, base[a[15:14]], a[13:0]};
		else if (idx == DL_IDX_EXT)
			return {1'b1, mdl, pg[8], 8'(pg[7:0] + a[21:14]), a[13:0]};
		return '0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			$display("Done: errors found");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	//////////////////////////////////////////////////
	// Driver

	task automatic start_download(input logic [7:0] idx, input logic [15:0] ext);
		logic [9:0] s;
		dl_active = 1'b0;
		@(posedge clk_sys);
		#1;
		dl_active = 1'b1;
		dl_index  = idx;
		dl_ext    = ext;
		if (idx == DL_IDX_EXT) begin
			s         = ext_start_page(ext);
			ref_page  = s[8:0];
			ref_combo = s[9];
		end
	endtask

	// Holds the byte until taken and queues its write before the edge
	task automatic send_byte(input logic [24:0] a, input logic [7:0] d);
		logic [24:0] w;
		int          t;
		dl_valid = 1'b1;
		dl_addr  = a;
		dl_data  = d;
		t = 0;
		@(negedge clk_sys);
		while (!dl_ready) begin
			t++;
			if (t > 50)
				abort_run("Timeout: download byte was never accepted");
			@(negedge clk_sys);
		end
		w = expect_write(dl_index, model, ref_page, a);
		if (w[24]) begin
			expect_q.push_back({w[23:0], d});
			if (w[22])
				loaded_ref[w[21:14]] = 1'b1;
		end
		if (dl_index == DL_IDX_EXT && ref_combo && a[13:0] == 14'h3FFF) begin
			ref_page  = PAGE_TOP;  // Second half of a combo image
			ref_combo = 1'b0;
		end
		@(posedge clk_sys);
		#1;
		dl_valid = 1'b0;
	endtask

	// Memory stalls
	initial begin
		logic [31:0] s;
		s = xorshift(32'd74508);
		mem_ready = 1'b1;
		forever begin
			@(posedge clk_sys);
			#1;
			s = xorshift(s);
			mem_ready = !stall_en || s[3:0] > 4'd5;
		end
	end

	// Comparison on each memory transfer
	initial begin
		logic [31:0] exp;
		forever begin
			@(negedge clk_sys);
			if (mem_valid && mem_ready) begin
				if (expect_q.size() == 0)
					abort_run($sformatf("Unexpected memory write to address %h", mem_addr));
				exp = expect_q.pop_front();
				check_value(test_name, exp, {mem_bank, mem_addr, mem_data});
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		int t;
		dl_active = 1'b0;
		dl_index  = 8'd0;
		dl_ext    = 16'd0;
		dl_valid  = 1'b0;
		dl_addr   = '0;
		dl_data   = 8'd0;
		model     = 1'b0;
		cpu_addr  = '0;
		for (int p = 0; p < 256; p++)
			loaded_ref[p] = 1'b0;
		t = 0;
		@(negedge clk_sys);
		while (reset) begin
			t++;
			if (t > 20)
				abort_run("Timeout: reset was never released");
			@(negedge clk_sys);
		end

		test_name = "rom download";  // Slots 8 and 9 must vanish
		start_download(DL_IDX_ROM, "RM");
		for (int s = 0; s < 10; s++) begin
			rng = xorshift(rng);
			send_byte({11'(s), 14'h0000}, rng[7:0]);
			send_byte({11'(s), rng[21:8]}, rng[29:22]);
			send_byte({11'(s), 14'h3FFF}, rng[15:8]);
		end

		test_name = "ext pages";
		for (int i = 0; i < 4; i++) begin
			model = i[0];
			start_download(DL_IDX_EXT, ext_names[i]);
			for (int k = 0; k < 6; k++) begin
				rng = xorshift(rng);
				send_byte(rng[24:0], rng[31:24]);
			end
		end

		test_name = "combo";
		start_download(DL_IDX_EXT, "Z0");
		send_byte({3'd0, 8'd0, 14'h0000}, 8'h11);
		send_byte({3'd0, 8'd0, 14'h1234}, 8'h22);
		send_byte({3'd0, 8'd0, 14'h3FFF}, 8'h33);
		send_byte({3'd0, 8'd0, 14'h0100}, 8'h44);  // Now on the top page
		send_byte({3'd0, 8'd1, 14'h0ABC}, 8'h55);

		test_name = "back-pressure";
		stall_en = 1'b1;
		start_download(DL_IDX_ROM, "RM");
		for (int k = 0; k < 20; k++) begin
			rng = xorshift(rng);
			send_byte({8'd0, rng[16:0]}, rng[31:24]);
		end
		model = 1'b1;
		start_download(DL_IDX_EXT, "A5");
		for (int k = 0; k < 20; k++) begin
			rng = xorshift(rng);
			send_byte(rng[24:0], rng[31:24]);
		end
		stall_en = 1'b0;

		test_name = "other index";
		start_download(8'd4, "XX");
		for (int k = 0; k < 8; k++) begin
			rng = xorshift(rng);
			send_byte(rng[24:0], rng[31:24]);
		end

		t = 0;
		@(negedge clk_sys);
		while (expect_q.size() != 0 || mem_valid) begin
			t++;
			if (t > 300)
				abort_run("Timeout: expected memory writes never arrived");
			@(negedge clk_sys);
		end

		// Every ROM page, then the same indices outside the ROM area
		test_name = "rom_mask";
		for (int p = 0; p < 512; p++) begin
			rng = xorshift(rng);
			@(posedge clk_sys);
			#1;
			cpu_addr = {~p[8], p[7:0], rng[13:0]};
			@(negedge clk_sys);
			check_value(test_name, (!p[8] && !loaded_ref[p[7:0]]), rom_mask);
		end

		if (u_cpc_loader_top.u_boot_addr_map.u_props.fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== project.f ====
src/cpc_loader_pkg.sv
src/mem_write_if.sv
src/ext_page_decoder.sv
src/boot_addr_map.sv
src/rom_page_table.sv
src/cpc_loader_top.sv
tb/clock_gen.sv
tb/cpc_loader_props.sv
tb/tb_cpc_loader.sv
